//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_zs_conv
FILELIST  := src.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := \*\*\* TEST PASSED \*\*\*

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;  // released on the fifth rising edge.
    end

endmodule

//--- bench/tb_zs_conv.sv
`timescale 1ns/1ns

module tb_zs_conv;

    import zs_pkg::*;

    localparam int NUM_PIXELS = 16;
    localparam int IN_ADDR_W  = 12;
    localparam int IN_DEPTH   = 1 << IN_ADDR_W;
    localparam int W_DEPTH    = 1 << CHANNEL_W;
    localparam int WAIT_LIMIT = 1000;

    logic                 clk;
    logic                 reset;
    logic                 ps_loading;
    logic [IN_ADDR_W-1:0] in_addr;
    entry_t               in_rd = '0;
    logic [CHANNEL_W-1:0] weight_addr;
    logic [DATA_W-1:0]    weight_rddata = '0;
    out_wr_t              out_wr;
    logic                 pl_need_weights;
    logic                 pl_need_data;

    entry_t            in_mem [IN_DEPTH];
    logic [DATA_W-1:0] w_mem [W_DEPTH];
    logic [DATA_W-1:0] w_table [W_DEPTH];  // weights of the case being read.
    entry_t            in_q[$];
    entry_t            file_q[$];
    entry_t            exp_q[$];
    entry_t            got_q[$];
    logic              loaded;
    int                seed;
    int                num_cases;

    tb_clock_gen u_clk (
        .clk   (clk),
        .reset (reset)
    );

    zs_conv_top #(.NUM_PIXELS(NUM_PIXELS), .IN_ADDR_W(IN_ADDR_W)) u_dut (
        .clk             (clk),
        .reset           (reset),
        .ps_loading      (ps_loading),
        .in_addr         (in_addr),
        .in_rd           (in_rd),
        .weight_addr     (weight_addr),
        .weight_rddata   (weight_rddata),
        .out_wr          (out_wr),
        .pl_need_weights (pl_need_weights),
        .pl_need_data    (pl_need_data)
    );

    // both memories answer one cycle after the address.
    always @(posedge clk) begin
        in_rd         <= in_mem[in_addr];
        weight_rddata <= w_mem[weight_addr];
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at time %0t", $time);
    endtask

    task automatic report_mismatch(input string name, input logic [DATA_W-1:0] got,
                                   input logic [DATA_W-1:0] exp);
        abort_run($sformatf("Error: time %0t %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_entry(input string name, input int k, input entry_t got,
                               input entry_t exp);
        a_value: assert (got.value == exp.value)
            else report_mismatch($sformatf("%s[%0d].value", name, k), got.value, exp.value);
        a_position: assert (got.position == exp.position)
            else report_mismatch($sformatf("%s[%0d].position", name, k), got.position,
                                 exp.position);
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            if (ps_loading) begin
                a_addr_held: assert (in_addr == '0)
                    else report_mismatch("in_addr", 32'(in_addr), 32'h0);
            end
            if (out_wr.en) begin
                a_no_early: assert (loaded)
                    else abort_run("out_wr.en pulsed before the first load");
                a_one_stop: assert (got_q.size() == 0 || got_q[$].position != STOP_WORD)
                    else abort_run("out_wr.en pulsed after the stop-word entry");
                a_out_addr: assert (out_wr.addr == 32'(got_q.size()))
                    else report_mismatch("out_wr.addr", out_wr.addr, 32'(got_q.size()));
                got_q.push_back(out_wr.entry);
            end
        end
    end

    // words past the list end carry their own address so a stray read shows up.
    function automatic entry_t fill_input(input int a);
        entry_t e;
        e.value    = 32'hBAD0_0000 | 32'(a);
        e.position = 32'(a) & 32'h0000_0FFF;
        return e;
    endfunction

    function automatic void reset_case_data();
        for (int c = 0; c < W_DEPTH; c++) begin
            w_table[c] = {8{4'(c)}};
        end
        in_q.delete();
        file_q.delete();
    endfunction

    // sums of value times signed lane weight per map and pixel, then relu and the stop word.
    task automatic build_expected();
        longint            sums [NUM_MAPS][NUM_PIXELS];
        logic [DATA_W-1:0] word;
        logic [DATA_W-1:0] low;
        int                px;
        entry_t            e;
        for (int m = 0; m < NUM_MAPS; m++) begin
            for (int p = 0; p < NUM_PIXELS; p++) begin
                sums[m][p] = 0;
            end
        end
        exp_q.delete();
        for (int k = 0; k < in_q.size(); k++) begin
            if (in_q[k].position == STOP_WORD) break;
            px   = int'(in_q[k].position[7:0]);
            word = w_table[in_q[k].position[11:8]];
            a_pattern_pixel: assert (px < NUM_PIXELS)
                else abort_run("pattern pixel lies beyond the map size");
            for (int m = 0; m < NUM_MAPS; m++) begin
                sums[m][px] += longint'($signed(in_q[k].value))
                             * longint'($signed(word[4*m +: 4]));
            end
        end
        for (int m = 0; m < NUM_MAPS; m++) begin
            for (int p = 0; p < NUM_PIXELS; p++) begin
                low = sums[m][p][31:0];
                if ($signed(low) > 0) begin
                    e.value    = low;
                    e.position = (32'(m) << 8) | 32'(p);
                    exp_q.push_back(e);
                end
            end
        end
        e.value    = STOP_WORD;
        e.position = STOP_WORD;
        exp_q.push_back(e);
    endtask

    task automatic wait_need_flags(input logic level);
        int n;
        n = 0;
        while (!(pl_need_weights == level && pl_need_data == level)) begin
            @(posedge clk);
            n++;
            a_need_timeout: assert (n <= WAIT_LIMIT)
                else abort_run($sformatf("need flags did not reach %0b in time", level));
        end
    endtask

    task automatic run_case();
        int gap;
        int n;
        build_expected();
        a_file_len: assert (file_q.size() == exp_q.size())
            else report_mismatch("pattern list length", file_q.size(), exp_q.size());
        for (int k = 0; k < exp_q.size(); k++) begin
            check_entry("pattern entry", k, file_q[k], exp_q[k]);
        end
        gap = $random(seed) & 7;
        repeat (gap) @(posedge clk);
        @(posedge clk);
        ps_loading <= 1'b1;
        loaded     <= 1'b1;
        wait_need_flags(1'b0);
        for (int a = 0; a < IN_DEPTH; a++) begin
            in_mem[a] <= (a < in_q.size()) ? in_q[a] : fill_input(a);
        end
        for (int c = 0; c < W_DEPTH; c++) begin
            w_mem[c] <= w_table[c];
        end
        got_q.delete();
        @(posedge clk);
        ps_loading <= 1'b0;
        n = 0;
        while (!(out_wr.en && out_wr.entry.position == STOP_WORD)) begin
            @(posedge clk);
            n++;
            a_stop_timeout: assert (n <= WAIT_LIMIT)
                else abort_run("the layer wrote no stop-word entry in time");
        end
        wait_need_flags(1'b1);
        a_out_len: assert (got_q.size() == exp_q.size())
            else report_mismatch("output list length", got_q.size(), exp_q.size());
        for (int k = 0; k < exp_q.size(); k++) begin
            check_entry("out_wr.entry", k, got_q[k], exp_q[k]);
        end
        num_cases++;
    endtask

    initial begin
        int                fd;
        int                n;
        string             line;
        byte               kind;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        entry_t            e;
        seed       = 32'h59386dfa;
        num_cases  = 0;
        ps_loading <= 1'b0;
        loaded     <= 1'b0;
        reset_case_data();
        for (int k = 0; k < IN_DEPTH; k++) begin
            in_mem[k] <= fill_input(k);
        end
        for (int c = 0; c < W_DEPTH; c++) begin
            w_mem[c] <= w_table[c];
        end
        @(posedge clk);
        n = 0;
        while (reset) begin
            @(posedge clk);
            n++;
            a_reset_timeout: assert (n <= WAIT_LIMIT)
                else abort_run("reset was never released");
        end
        a_need_after_reset: assert (pl_need_weights && pl_need_data)
            else abort_run("the need flags are not both high after reset");
        fd = $fopen("bench/zs_conv_patterns.txt", "r");
        a_file_open: assert (fd != 0)
            else abort_run("cannot open bench/zs_conv_patterns.txt");
        while ($fgets(line, fd) != 0) begin
            kind = line.getc(0);
            if (kind == "#" || kind == " " || kind == "\n" || kind == "\r") continue;
            if (kind == "r") begin
                run_case();
                reset_case_data();
                continue;
            end
            n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
            a_line_format: assert (n == 2)
                else abort_run($sformatf("malformed pattern line %s", line));
            e.value    = a;
            e.position = b;
            case (kind)
                "w": w_table[a[CHANNEL_W-1:0]] = b;
                "i": in_q.push_back(e);
                "e": file_q.push_back(e);
                default: abort_run($sformatf("unknown pattern line %s", line));
            endcase
        end
        $fclose(fd);
        a_cases_run: assert (num_cases > 0)
            else abort_run("the pattern file holds no complete case");
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- bench/zs_conv_patterns.txt
# columns are kind, a, b in hex. w is channel and weight word, i is input value and
# position, e is expected output value and position, r runs the case above it.
# mixed signs over two channels with three pixels.
w 0 87E30F21
w 1 101D021F
i 00000005 00000003
i 00000002 00000103
i FFFFFFFC 0000000A
i 00000003 00000100
i FFFFFFFF FFFFFFFF
e 00000003 00000003
e 00000003 00000100
e 0000000C 00000103
e 00000006 00000200
e 00000004 0000020A
e 00000009 00000403
e 00000003 00000500
e 00000008 0000050A
e 00000023 00000603
e 00000003 00000700
e 00000020 0000070A
e FFFFFFFF FFFFFFFF
r
# empty input list.
i FFFFFFFF FFFFFFFF
e FFFFFFFF FFFFFFFF
r
# pixel 15 wraps negative, pixel 1 sums to 13 in every map.
w 2 FFFFFFFF
w F 77777777
i 10000000 00000F0F
i 10000000 00000F0F
i 00000002 0000020F
i 00000003 00000207
i FFFFFFFA 00000201
i 00000001 00000F01
i FFFFFFFF FFFFFFFF
e 0000000D 00000001
e 0000000D 00000101
e 0000000D 00000201
e 0000000D 00000301
e 0000000D 00000401
e 0000000D 00000501
e 0000000D 00000601
e 0000000D 00000701
e FFFFFFFF FFFFFFFF
r
w 0 87E30F21
i 00000001 00000003
i FFFFFFFF FFFFFFFF
e 00000001 00000003
e 00000002 00000103
e 00000003 00000403
e 00000007 00000603
e FFFFFFFF FFFFFFFF
r

//--- src.f
src/zs_pkg.sv
src/zs_layer_ctrl.sv
src/zs_fetch.sv
src/zs_pointwise_accum.sv
src/zs_relu_writer.sv
src/zs_conv_top.sv
bench/tb_clock_gen.sv
bench/tb_zs_conv.sv

//--- src/zs_conv_top.sv
`timescale 1ns/1ns

module zs_conv_top #(
    parameter int NUM_PIXELS = 16,
    parameter int IN_ADDR_W  = 12
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         ps_loading,
    output logic [IN_ADDR_W-1:0]         in_addr,
    input  zs_pkg::entry_t               in_rd,
    output logic [zs_pkg::CHANNEL_W-1:0] weight_addr,
    input  logic [zs_pkg::DATA_W-1:0]    weight_rddata,
    output zs_pkg::out_wr_t              out_wr,
    output logic                         pl_need_weights,
    output logic                         pl_need_data
);

    import zs_pkg::*;

    logic                     clear;
    logic                     run;
    logic                     layer_done;
    logic                     flushed;
    elem_t                    elem;
    logic signed [DATA_W-1:0] acc [NUM_MAPS][NUM_PIXELS];

    zs_layer_ctrl u_ctrl (
        .clk             (clk),
        .reset           (reset),
        .ps_loading      (ps_loading),
        .layer_done      (layer_done),
        .pl_need_weights (pl_need_weights),
        .pl_need_data    (pl_need_data),
        .clear           (clear),
        .run             (run)
    );

    zs_fetch #(.IN_ADDR_W(IN_ADDR_W)) u_fetch (
        .clk         (clk),
        .reset       (reset),
        .clear       (clear),
        .run         (run),
        .in_addr     (in_addr),
        .in_rd       (in_rd),
        .weight_addr (weight_addr),
        .elem        (elem)
    );

    zs_pointwise_accum #(.NUM_PIXELS(NUM_PIXELS)) u_accum (
        .clk           (clk),
        .reset         (reset),
        .clear         (clear),
        .elem          (elem),
        .weight_rddata (weight_rddata),
        .acc           (acc),
        .flushed       (flushed)
    );

    zs_relu_writer #(.NUM_PIXELS(NUM_PIXELS)) u_writer (
        .clk        (clk),
        .reset      (reset),
        .clear      (clear),
        .acc        (acc),
        .flushed    (flushed),
        .out_wr     (out_wr),
        .layer_done (layer_done)
    );

endmodule

//--- src/zs_fetch.sv
`timescale 1ns/1ns

module zs_fetch #(
    parameter int IN_ADDR_W = 12
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         clear,
    input  logic                         run,
    output logic [IN_ADDR_W-1:0]         in_addr,
    input  zs_pkg::entry_t               in_rd,
    output logic [zs_pkg::CHANNEL_W-1:0] weight_addr,
    output zs_pkg::elem_t                elem
);

    import zs_pkg::*;

    logic rd_pending;  // a word asked for last cycle is on in_rd now.
    logic stopped;
    logic stop_now;
    logic issue;

    assign stop_now = rd_pending && (in_rd.position == STOP_WORD);
    assign issue    = run && !stopped && !stop_now;

    // the weight word for this channel comes back together with the registered element.
    assign weight_addr = in_rd.position[8 +: CHANNEL_W];

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            in_addr    <= '0;
            rd_pending <= 1'b0;
            stopped    <= 1'b0;
        end else begin
            rd_pending <= issue;
            if (issue) begin
                in_addr <= in_addr + 1'b1;
            end
            if (stop_now) begin
                stopped <= 1'b1;  // the read already in flight behind it is dropped.
            end
        end
    end

    always_ff @(posedge clk) begin
        elem.value   <= in_rd.value;
        elem.channel <= in_rd.position[8 +: CHANNEL_W];
        elem.pixel   <= in_rd.position[PIXEL_W-1:0];
        if (reset || clear) begin
            elem.valid <= 1'b0;
            elem.last  <= 1'b0;
        end else begin
            elem.valid <= rd_pending && !stop_now;
            elem.last  <= stop_now;
        end
    end

    // data words carry only a channel and a pixel.
    a_position_clean: assert property (@(posedge clk) disable iff (reset || clear)
        (rd_pending && !stop_now) |-> (in_rd.position[DATA_W-1:16] == '0))
        else $error("input position has bits set above 15");

endmodule

//--- src/zs_layer_ctrl.sv
`timescale 1ns/1ns

module zs_layer_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic ps_loading,
    input  logic layer_done,
    output logic pl_need_weights,
    output logic pl_need_data,
    output logic clear,
    output logic run
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOADING,
        ST_RUN
    } state_t;

    state_t state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state           <= ST_IDLE;
            pl_need_weights <= 1'b1;
            pl_need_data    <= 1'b1;
            clear           <= 1'b1;
            run             <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (ps_loading) begin
                        pl_need_weights <= 1'b0;  // the processor has taken the request.
                        pl_need_data    <= 1'b0;
                        state           <= ST_LOADING;
                    end
                end
                ST_LOADING: begin
                    if (!ps_loading) begin  // both memories are filled now.
                        clear <= 1'b0;
                        run   <= 1'b1;
                        state <= ST_RUN;
                    end
                end
                ST_RUN: begin
                    if (layer_done) begin
                        clear           <= 1'b1;  // wipes all units for the next layer.
                        run             <= 1'b0;
                        pl_need_weights <= 1'b1;
                        pl_need_data    <= 1'b1;
                        state           <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // the writer may only finish a layer that the controller has started.
    a_done_in_run: assert property (@(posedge clk) disable iff (reset)
        layer_done |-> (state == ST_RUN))
        else $error("layer_done outside the run state");

endmodule

//--- src/zs_pkg.sv
package zs_pkg;

    parameter int DATA_W    = 32;
    parameter int WEIGHT_W  = 4;
    parameter int NUM_MAPS  = 8;   // also the number of weight lanes per word.
    parameter int CHANNEL_W = 4;
    parameter int PIXEL_W   = 4;

    // ends both the input and the output list.
    parameter logic [DATA_W-1:0] STOP_WORD = '1;

    // one word of a sparse list whose position holds channel or map in 15:8 and pixel in 7:0.
    typedef struct packed {
        logic [DATA_W-1:0] value;
        logic [DATA_W-1:0] position;
    } entry_t;

    typedef struct packed {
        logic                 valid;
        logic                 last;    // the stop word went past.
        logic [DATA_W-1:0]    value;
        logic [CHANNEL_W-1:0] channel;
        logic [PIXEL_W-1:0]   pixel;
    } elem_t;

    typedef struct packed {
        logic              en;
        logic [DATA_W-1:0] addr;
        entry_t            entry;
    } out_wr_t;

endpackage

//--- src/zs_pointwise_accum.sv
`timescale 1ns/1ns

module zs_pointwise_accum #(
    parameter int NUM_PIXELS = 16
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             clear,
    input  zs_pkg::elem_t                    elem,
    input  logic [zs_pkg::DATA_W-1:0]        weight_rddata,
    output logic signed [zs_pkg::DATA_W-1:0] acc [zs_pkg::NUM_MAPS][NUM_PIXELS],
    output logic                             flushed
);

    import zs_pkg::*;

    logic signed [WEIGHT_W-1:0] lane [NUM_MAPS];
    logic signed [DATA_W-1:0]   prod [NUM_MAPS];

    // lane m sits in bits 4m+3:4m of the weight word and feeds output map m.
    always_comb begin
        for (int m = 0; m < NUM_MAPS; m++) begin
            lane[m] = weight_rddata[m*WEIGHT_W +: WEIGHT_W];
            prod[m] = $signed(elem.value) * lane[m];  // keeps the low 32 bits.
        end
    end

    always_ff @(posedge clk) begin
        if (clear) begin
            for (int m = 0; m < NUM_MAPS; m++) begin
                for (int p = 0; p < NUM_PIXELS; p++) begin
                    acc[m][p] <= '0;
                end
            end
        end else if (elem.valid) begin
            for (int m = 0; m < NUM_MAPS; m++) begin
                acc[m][elem.pixel] <= acc[m][elem.pixel] + prod[m];
            end
        end
    end

    // every element ahead of the marker has been summed when it arrives.
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            flushed <= 1'b0;
        end else if (elem.last) begin
            flushed <= 1'b1;
        end
    end

    // the input list must stay inside the configured map size.
    a_pixel_range: assert property (@(posedge clk) disable iff (reset || clear)
        elem.valid |-> (int'(elem.pixel) < NUM_PIXELS))
        else $error("pixel index beyond NUM_PIXELS");

endmodule

//--- src/zs_relu_writer.sv
`timescale 1ns/1ns

module zs_relu_writer #(
    parameter int NUM_PIXELS = 16
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             clear,
    input  logic signed [zs_pkg::DATA_W-1:0] acc [zs_pkg::NUM_MAPS][NUM_PIXELS],
    input  logic                             flushed,
    output zs_pkg::out_wr_t                  out_wr,
    output logic                             layer_done
);

    import zs_pkg::*;

    localparam int MAP_CNT_W = $clog2(NUM_MAPS);
    localparam int PIX_CNT_W = (NUM_PIXELS > 1) ? $clog2(NUM_PIXELS) : 1;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_SCAN,
        WR_STOP
    } wr_state_t;

    wr_state_t              state;
    logic                   finished;  // one scan per layer.
    logic [MAP_CNT_W-1:0]   map_cnt;
    logic [PIX_CNT_W-1:0]   pix_cnt;
    logic [DATA_W-1:0]      out_addr;
    logic signed [DATA_W-1:0] cur;
    logic                   last_pix;
    logic                   last_cell;

    assign cur       = acc[map_cnt][pix_cnt];
    assign last_pix  = (pix_cnt == PIX_CNT_W'(NUM_PIXELS - 1));
    assign last_cell = last_pix && (map_cnt == MAP_CNT_W'(NUM_MAPS - 1));

    always_ff @(posedge clk) begin
        out_wr.addr <= out_addr;
        if (state == WR_STOP) begin
            out_wr.entry.value    <= STOP_WORD;
            out_wr.entry.position <= STOP_WORD;
        end else begin
            out_wr.entry.value    <= cur;
            out_wr.entry.position <= (DATA_W'(map_cnt) << 8) | DATA_W'(pix_cnt);
        end
        if (reset || clear) begin
            state      <= WR_IDLE;
            finished   <= 1'b0;
            map_cnt    <= '0;
            pix_cnt    <= '0;
            out_addr   <= '0;
            out_wr.en  <= 1'b0;
            layer_done <= 1'b0;
        end else begin
            out_wr.en  <= 1'b0;
            layer_done <= 1'b0;
            case (state)
                WR_IDLE: begin
                    if (flushed && !finished) begin
                        map_cnt <= '0;
                        pix_cnt <= '0;
                        state   <= WR_SCAN;
                    end
                end
                WR_SCAN: begin
                    if (cur > 0) begin  // relu drops zero and negative sums.
                        out_wr.en <= 1'b1;
                        out_addr  <= out_addr + 1'b1;
                    end
                    if (last_cell) begin
                        state <= WR_STOP;
                    end else if (last_pix) begin
                        pix_cnt <= '0;
                        map_cnt <= map_cnt + 1'b1;
                    end else begin
                        pix_cnt <= pix_cnt + 1'b1;
                    end
                end
                WR_STOP: begin
                    out_wr.en  <= 1'b1;
                    out_addr   <= out_addr + 1'b1;
                    layer_done <= 1'b1;
                    finished   <= 1'b1;
                    state      <= WR_IDLE;
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

endmodule
